// ==== vlog.f ====
ps2_pkg.sv
ps2_line_if.sv
ps2_interval_timer.sv
ps2_line_frontend.sv
ps2_receiver.sv
ps2_transmitter.sv
ps2_host_port.sv
ps2_host_port_assert.sv
tb_ps2_host_port.sv

// ==== Bender.yml ====
package:
  name: ps2_host_port

sources:
  # RTL in compile order
  - ps2_pkg.sv
  - ps2_line_if.sv
  - ps2_interval_timer.sv
  - ps2_line_frontend.sv
  - ps2_receiver.sv
  - ps2_transmitter.sv
  - ps2_host_port.sv
  # bound checker and testbench
  - target: test
    files:
      - ps2_host_port_assert.sv
      - tb_ps2_host_port.sv

// ==== tb_ps2_host_port.sv ====
// PS/2 host port testbench: device model, random receive and transmit traffic, reference checks
`timescale 1ns/1ps

module tb_ps2_host_port;

  localparam int SEED            = 28671;
  // 10 us half-bit period of the device at a 4 ns clock
  localparam int HALF_CYCLES     = 2500;
  // the device drives its acknowledge this many clocks before its clock fall
  localparam int ACK_SETUP       = 8;
  localparam int WAIT_TIMEOUT    = 4 * HALF_CYCLES;
  localparam int INHIBIT_TIMEOUT = ps2_pkg::INHIBIT_CYCLES + 1000;
  localparam int QUIET_CYCLES    = ps2_pkg::WATCHDOG_CYCLES + 1000;

  logic       clk;
  logic       reset;
  logic       dev_clk;
  logic       dev_data;
  logic       ps2_clk;
  logic       ps2_data;
  logic       ps2_clk_pull_o;
  logic       ps2_data_pull_o;
  logic [7:0] rx_code_o;
  logic       rx_ready_o;
  logic       rx_read_i;
  logic [7:0] tx_data_i;
  logic       tx_write_i;
  logic       tx_ack_o;
  logic       tx_error_o;

  int         error_count;
  int         timeout_count;
  int         error_cycles;
  logic [7:0] expected_codes[$];

  // open-drain lines where either side can pull low
  assign ps2_clk  = dev_clk & ~ps2_clk_pull_o;
  assign ps2_data = dev_data & ~ps2_data_pull_o;

  ps2_host_port i_ps2_host_port (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk_i       (ps2_clk),
    .ps2_data_i      (ps2_data),
    .ps2_clk_pull_o  (ps2_clk_pull_o),
    .ps2_data_pull_o (ps2_data_pull_o),
    .rx_code_o       (rx_code_o),
    .rx_ready_o      (rx_ready_o),
    .rx_read_i       (rx_read_i),
    .tx_data_i       (tx_data_i),
    .tx_write_i      (tx_write_i),
    .tx_ack_o        (tx_ack_o),
    .tx_error_o      (tx_error_o)
  );

  bind ps2_host_port ps2_host_port_assert i_host_port_assert (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk_pull_o  (ps2_clk_pull_o),
    .ps2_data_pull_o (ps2_data_pull_o),
    .rx_ready_o      (rx_ready_o),
    .rx_read_i       (rx_read_i),
    .tx_write_i      (tx_write_i),
    .tx_ack_o        (tx_ack_o),
    .tx_error_o      (tx_error_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // counts every clock with the error flag up
  always @(posedge clk)
  begin
    if (tx_error_o)
      error_cycles <= error_cycles + 1;
  end

  // ---------------------------------------------------------
  // reporting
  // ---------------------------------------------------------

  task automatic finish_run();
    $display("closing: %0d value errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("timed out at %0t waiting for %s", $time, what);
  endtask

  task automatic expect_true(input bit ok, input string msg);
    assert (ok)
    else
    begin
      error_count++;
      $display("ERR %0t: %s", $time, msg);
    end
  endtask

  // ---------------------------------------------------------
  // reference model and device model
  // ---------------------------------------------------------

  // start 0, data LSB first, odd parity over data and parity, stop 1
  function automatic logic [10:0] build_frame(input logic [7:0] code);
    logic [10:0] frame;
    frame[0] = 1'b0;
    for (int i = 0; i < 8; i++)
      frame[i + 1] = code[i];
    // the parity bit is set when the data byte holds an even number of ones
    frame[9]  = ($countones(code) % 2 == 0);
    frame[10] = 1'b1;
    return frame;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // the device backs off when it finds its clock held low by the host
  task automatic device_send_frame(input logic [7:0] code, input int nbits, output bit aborted);
    logic [10:0] frame;
    int          t;
    frame   = build_frame(code);
    aborted = 1'b0;
    for (int i = 0; i < nbits && !aborted; i++)
    begin
      dev_data = frame[i];
      t = 0;
      while (t < HALF_CYCLES && !aborted)
      begin
        @(negedge clk);
        t++;
        if (ps2_clk === 1'b0)
          aborted = 1'b1;
      end
      if (!aborted)
      begin
        dev_clk = 1'b0;
        idle_cycles(HALF_CYCLES);
        dev_clk = 1'b1;
      end
    end
    dev_data = 1'b1;
  endtask

  // reads a host frame one bit before each clock fall and leaves the clock low after the last
  task automatic device_read_host_frame(input bit give_ack, output logic [10:0] bits,
                                        output int pull_cycles);
    int t;
    t = 0;
    while (!ps2_clk_pull_o && t < WAIT_TIMEOUT)
    begin
      @(negedge clk);
      t++;
    end
    if (!ps2_clk_pull_o)
      report_timeout("the clock inhibit to start");
    pull_cycles = 0;
    while (ps2_clk_pull_o && pull_cycles < INHIBIT_TIMEOUT)
    begin
      @(negedge clk);
      pull_cycles++;
    end
    if (ps2_clk_pull_o)
      report_timeout("the clock inhibit to end");
    for (int i = 0; i < ps2_pkg::FRAME_BITS; i++)
    begin
      idle_cycles(HALF_CYCLES);
      bits[i] = ps2_data;
      // the acknowledge slot is the fall right after the stop bit
      if (i == ps2_pkg::FRAME_BITS - 1 && give_ack)
      begin
        dev_data = 1'b0;
        idle_cycles(ACK_SETUP);
      end
      dev_clk = 1'b0;
      idle_cycles(HALF_CYCLES);
      if (i < ps2_pkg::FRAME_BITS - 1)
        dev_clk = 1'b1;
    end
  endtask

  task automatic release_lines();
    dev_clk  = 1'b1;
    dev_data = 1'b1;
  endtask

  // ---------------------------------------------------------
  // host side
  // ---------------------------------------------------------

  task automatic wait_rx_ready(input string what);
    int t;
    t = 0;
    while (rx_ready_o !== 1'b1 && t < WAIT_TIMEOUT)
    begin
      @(negedge clk);
      t++;
    end
    if (rx_ready_o !== 1'b1)
      report_timeout(what);
  endtask

  task automatic wait_tx_error(input logic level, input string what);
    int t;
    t = 0;
    while (tx_error_o !== level && t < WAIT_TIMEOUT)
    begin
      @(negedge clk);
      t++;
    end
    if (tx_error_o !== level)
      report_timeout(what);
  endtask

  // ack is combinational, so it is sampled halfway through the low clock phase
  task automatic host_write(input logic [7:0] code);
    int t;
    tx_data_i  = code;
    tx_write_i = 1'b1;
    t = 0;
    #1;
    while (!tx_ack_o && t < WAIT_TIMEOUT)
    begin
      @(negedge clk);
      #1;
      t++;
    end
    if (!tx_ack_o)
      report_timeout("tx_ack_o after a write");
    @(negedge clk);
    tx_write_i = 1'b0;
  endtask

  task automatic check_received_byte();
    logic [7:0] expected;
    int         hold;
    wait_rx_ready("rx_ready_o after a device frame");
    expected = expected_codes.pop_front();
    expect_true(rx_code_o == expected,
                $sformatf("rx_code_o is %h, expected %h", rx_code_o, expected));
    // back-pressure from the host must not lose the flag
    hold = $urandom_range(40);
    repeat (hold)
    begin
      @(negedge clk);
      expect_true(rx_ready_o, "rx_ready_o dropped before a read");
    end
    rx_read_i = 1'b1;
    @(negedge clk);
    rx_read_i = 1'b0;
    expect_true(!rx_ready_o, "rx_ready_o still high after a read");
  endtask

  task automatic check_host_frame(input logic [7:0] code, input bit give_ack,
                                  input bit check_inhibit);
    logic [10:0] bits;
    int          pull_cycles;
    int          errors_before;
    errors_before = error_cycles;
    device_read_host_frame(give_ack, bits, pull_cycles);
    if (check_inhibit)
      expect_true(pull_cycles >= ps2_pkg::INHIBIT_CYCLES,
                  $sformatf("clock inhibit lasted only %0d cycles", pull_cycles));
    expect_true(bits == build_frame(code),
                $sformatf("host frame %b, expected %b", bits, build_frame(code)));
    if (give_ack)
    begin
      expect_true(error_cycles == errors_before, "tx_error_o rose on an acknowledged write");
      release_lines();
      // the device keeps both lines high for a while before its next frame
      idle_cycles(HALF_CYCLES);
    end
    else
    begin
      wait_tx_error(1'b1, "tx_error_o after a missing acknowledge");
      release_lines();
      wait_tx_error(1'b0, "tx_error_o to clear once the lines were idle");
    end
  endtask

  // ---------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------

  initial
  begin : stimulus
    logic [7:0] code;
    logic [7:0] write_code;
    bit         aborted;
    void'($urandom(SEED));
    error_count   = 0;
    timeout_count = 0;
    error_cycles  = 0;
    reset      = 1'b1;
    dev_clk    = 1'b1;
    dev_data   = 1'b1;
    rx_read_i  = 1'b0;
    tx_write_i = 1'b0;
    tx_data_i  = 8'h00;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // quiet outputs on idle lines
    repeat (200)
    begin
      @(negedge clk);
      expect_true(!rx_ready_o && !tx_ack_o && !tx_error_o && !ps2_clk_pull_o &&
                  !ps2_data_pull_o, "outputs not quiet on idle lines");
    end

    // random device bytes
    for (int i = 0; i < 20; i++)
    begin
      code = 8'($urandom);
      expected_codes.push_back(code);
      device_send_frame(code, ps2_pkg::FRAME_BITS, aborted);
      check_received_byte();
    end

    // random host writes, all acknowledged
    for (int i = 0; i < 10; i++)
    begin
      code = 8'($urandom);
      host_write(code);
      check_host_frame(code, 1'b1, 1'b1);
    end

    // a write the device refuses
    code = 8'($urandom);
    host_write(code);
    check_host_frame(code, 1'b0, 1'b1);

    // a stalled partial frame must be dropped by the watchdog
    device_send_frame(8'($urandom), 4, aborted);
    idle_cycles(QUIET_CYCLES);
    expect_true(!rx_ready_o, "rx_ready_o rose for a partial frame");
    code = 8'($urandom);
    expected_codes.push_back(code);
    device_send_frame(code, ps2_pkg::FRAME_BITS, aborted);
    check_received_byte();

    // host write lands in the middle of a device frame
    write_code = 8'($urandom);
    fork
      device_send_frame(8'($urandom), ps2_pkg::FRAME_BITS, aborted);
      begin
        idle_cycles(6 * HALF_CYCLES + $urandom_range(2 * HALF_CYCLES));
        host_write(write_code);
      end
    join
    expect_true(aborted, "device was not stopped by the clock inhibit");
    check_host_frame(write_code, 1'b1, 1'b0);
    expect_true(!rx_ready_o, "rx_ready_o rose for an aborted frame");
    code = 8'($urandom);
    expected_codes.push_back(code);
    device_send_frame(code, ps2_pkg::FRAME_BITS, aborted);
    check_received_byte();

    finish_run();
  end

endmodule

// ==== ps2_host_port_assert.sv ====
// PS/2 host port checker: concurrent assertions on the host handshakes and the pad drive
`timescale 1ns/1ps

module ps2_host_port_assert (
  input logic clk,
  input logic reset,
  input logic ps2_clk_pull_o,
  input logic ps2_data_pull_o,
  input logic rx_ready_o,
  input logic rx_read_i,
  input logic tx_write_i,
  input logic tx_ack_o,
  input logic tx_error_o
);

  // set once the clock inhibit of the current write has been seen
  logic clk_pull_seen_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      clk_pull_seen_q <= 1'b0;
    else if (tx_ack_o)
      clk_pull_seen_q <= 1'b0;
    else if (ps2_clk_pull_o)
      clk_pull_seen_q <= 1'b1;
  end

  // a byte is only taken away by the host
  ready_held_until_read: assert property (@(posedge clk) disable iff (reset)
    $fell(rx_ready_o) |-> $past(rx_read_i))
    else $error("rx_ready_o fell without a read");

  // an accepted write is acknowledged for one cycle and starts the clock inhibit
  ack_starts_inhibit: assert property (@(posedge clk) disable iff (reset)
    tx_ack_o |-> tx_write_i ##1 (!tx_ack_o && ps2_clk_pull_o))
    else $error("tx_ack_o without a write or not followed by the clock inhibit");

  // the start bit may only follow the inhibit
  data_pull_after_clk_pull: assert property (@(posedge clk) disable iff (reset)
    ps2_data_pull_o |-> clk_pull_seen_q)
    else $error("data line pulled before the clock inhibit");

  quiet_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !rx_ready_o && !tx_ack_o && !tx_error_o &&
                     !ps2_clk_pull_o && !ps2_data_pull_o)
    else $error("control outputs not low after reset");

endmodule

// ==== ps2_host_port.sv ====
// PS/2 host port top level: joins the line front end, receiver and transmitter
`timescale 1ns/1ps

module ps2_host_port (
  input  logic       clk,
  input  logic       reset,
  // PS/2 pads, the pulls drive open-drain buffers
  input  logic       ps2_clk_i,
  input  logic       ps2_data_i,
  output logic       ps2_clk_pull_o,
  output logic       ps2_data_pull_o,
  // receive side toward the host
  output logic [7:0] rx_code_o,
  output logic       rx_ready_o,
  input  logic       rx_read_i,
  // transmit side from the host
  input  logic [7:0] tx_data_i,
  input  logic       tx_write_i,
  output logic       tx_ack_o,
  output logic       tx_error_o
);

  // samples go out to both engines, pulls come back from the transmitter
  ps2_line_if line ();

  // ---------------------------------------------------------
  // line front end
  // ---------------------------------------------------------

  ps2_line_frontend i_frontend (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk_i       (ps2_clk_i),
    .ps2_data_i      (ps2_data_i),
    .ps2_clk_pull_o  (ps2_clk_pull_o),
    .ps2_data_pull_o (ps2_data_pull_o),
    .line            (line.frontend)
  );

  // ---------------------------------------------------------
  // receive and transmit engines
  // ---------------------------------------------------------

  // both watch the same samples; a transmit in progress cancels a receive
  ps2_receiver i_receiver (
    .clk        (clk),
    .reset      (reset),
    .line       (line.receiver),
    .rx_read_i  (rx_read_i),
    .rx_code_o  (rx_code_o),
    .rx_ready_o (rx_ready_o)
  );

  ps2_transmitter i_transmitter (
    .clk        (clk),
    .reset      (reset),
    .line       (line.transmitter),
    .tx_write_i (tx_write_i),
    .tx_data_i  (tx_data_i),
    .tx_ack_o   (tx_ack_o),
    .tx_error_o (tx_error_o)
  );

endmodule

// ==== ps2_transmitter.sv ====
// PS/2 transmitter: runs a host write through inhibit, start, bit shifting and the acknowledge check
`timescale 1ns/1ps

module ps2_transmitter (
  input  logic                clk,
  input  logic                reset,
  ps2_line_if.transmitter     line,
  input  logic                tx_write_i,
  input  ps2_pkg::scan_code_t tx_data_i,
  output logic                tx_ack_o,
  output logic                tx_error_o
);

  ps2_pkg::tx_state_e state_q;
  ps2_pkg::tx_state_e state_d;

  logic [ps2_pkg::BIT_COUNT_W-1:0] bit_count_q;
  logic [ps2_pkg::FRAME_BITS-1:0]  shift_q;
  logic                            parity;
  logic                            rise_mark;
  logic                            bits_sent;
  logic                            inhibit_run;
  logic                            inhibit_done;
  logic                            debounce_run;
  logic                            debounce_done;

  // ---------------------------------------------------------
  // host handshake and frame load
  // ---------------------------------------------------------

  // a write is taken only from idle, and the same cycle loads the frame
  assign tx_ack_o = tx_write_i && (state_q == ps2_pkg::TX_IDLE);

  // odd parity makes the nine bits after the start bit hold an odd count of ones
  assign parity = ~^tx_data_i;

  // bit 0 is the bit currently on the line, released ones fill in from the top
  always_ff @(posedge clk)
  begin
    if (tx_ack_o)
      shift_q <= {1'b1, parity, tx_data_i, 1'b0};
    else if (rise_mark)
      shift_q <= {1'b1, shift_q[ps2_pkg::FRAME_BITS-1:1]};
  end

  // ---------------------------------------------------------
  // timers
  // ---------------------------------------------------------

  // the TX_LOAD cycle keeps this low, so the inhibit always starts from zero
  assign inhibit_run  = (state_q == ps2_pkg::TX_INHIBIT);
  assign debounce_run = (state_q == ps2_pkg::TX_START) || (state_q == ps2_pkg::TX_WAIT_HIGH);

  ps2_interval_timer #(
    .LIMIT (ps2_pkg::INHIBIT_CYCLES)
  ) i_inhibit_timer (
    .clk    (clk),
    .reset  (reset),
    .run_i  (inhibit_run),
    .done_o (inhibit_done)
  );

  ps2_interval_timer #(
    .LIMIT (ps2_pkg::DEBOUNCE_CYCLES)
  ) i_debounce_timer (
    .clk    (clk),
    .reset  (reset),
    .run_i  (debounce_run),
    .done_o (debounce_done)
  );

  // ---------------------------------------------------------
  // bit counter
  // ---------------------------------------------------------

  assign rise_mark = (state_q == ps2_pkg::TX_RISE_MARK);

  // ten rising edges move the start, data and parity bits out,
  // which leaves the stop bit in place of the released line
  assign bits_sent = (bit_count_q == ps2_pkg::BIT_COUNT_W'(ps2_pkg::FRAME_BITS - 1));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_count_q <= '0;
    else if (tx_ack_o)
      bit_count_q <= '0;
    else if (rise_mark)
      bit_count_q <= bit_count_q + 1'b1;
  end

  // ---------------------------------------------------------
  // transmit sequencer
  // ---------------------------------------------------------

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ps2_pkg::TX_IDLE:
      begin
        if (tx_ack_o)
          state_d = ps2_pkg::TX_LOAD;
      end
      ps2_pkg::TX_LOAD: state_d = ps2_pkg::TX_INHIBIT;
      ps2_pkg::TX_INHIBIT:
      begin
        if (inhibit_done)
          state_d = ps2_pkg::TX_START;
      end
      // the clock was only just released and its sample still lags,
      // so the device's first fall counts only after the debounce wait
      ps2_pkg::TX_START:
      begin
        if (!line.clk_s && debounce_done)
          state_d = ps2_pkg::TX_CLK_LOW;
      end
      ps2_pkg::TX_CLK_LOW:
      begin
        if (line.clk_s)
          state_d = ps2_pkg::TX_WAIT_HIGH;
      end
      ps2_pkg::TX_WAIT_HIGH:
      begin
        if (line.clk_s && debounce_done)
          state_d = ps2_pkg::TX_RISE_MARK;
      end
      ps2_pkg::TX_RISE_MARK: state_d = ps2_pkg::TX_CLK_HIGH;
      ps2_pkg::TX_CLK_HIGH:
      begin
        if (bits_sent)
          state_d = ps2_pkg::TX_WAIT_ACK;
        else if (!line.clk_s)
          state_d = ps2_pkg::TX_CLK_LOW;
      end
      // the device answers by holding data low at its next clock fall
      ps2_pkg::TX_WAIT_ACK:
      begin
        if (!line.clk_s && line.data_s)
          state_d = ps2_pkg::TX_NO_ACK;
        else if (!line.clk_s)
          state_d = ps2_pkg::TX_RECOVER;
      end
      ps2_pkg::TX_RECOVER, ps2_pkg::TX_NO_ACK:
      begin
        if (line.clk_s && line.data_s)
          state_d = ps2_pkg::TX_IDLE;
      end
      default: state_d = ps2_pkg::TX_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state_q <= ps2_pkg::TX_IDLE;
    else
      state_q <= state_d;
  end

  // ---------------------------------------------------------
  // line requests and status
  // ---------------------------------------------------------

  // clock inhibit covers the load cycle and the whole timed interval
  assign line.clk_pull = (state_q == ps2_pkg::TX_LOAD) || (state_q == ps2_pkg::TX_INHIBIT);

  // a zero bit pulls data low, a one bit leaves it to the pull-up
  always_comb
  begin
    case (state_q)
      ps2_pkg::TX_START: line.data_pull = 1'b1;
      ps2_pkg::TX_CLK_LOW,
      ps2_pkg::TX_WAIT_HIGH,
      ps2_pkg::TX_RISE_MARK,
      ps2_pkg::TX_CLK_HIGH: line.data_pull = !shift_q[0];
      default: line.data_pull = 1'b0;
    endcase
  end

  assign line.tx_active = (state_q != ps2_pkg::TX_IDLE);

  // error stays up until the device lets both lines go high again
  assign tx_error_o = (state_q == ps2_pkg::TX_NO_ACK);

endmodule

// ==== ps2_receiver.sv ====
// PS/2 receiver: tracks device clock edges, shifts in frames and presents bytes through ready/read
`timescale 1ns/1ps

module ps2_receiver (
  input  logic                clk,
  input  logic                reset,
  ps2_line_if.receiver        line,
  input  logic                rx_read_i,
  output ps2_pkg::scan_code_t rx_code_o,
  output logic                rx_ready_o
);

  ps2_pkg::rx_state_e state_q;
  ps2_pkg::rx_state_e state_d;

  logic [ps2_pkg::BIT_COUNT_W-1:0] bit_count_q;
  logic [ps2_pkg::FRAME_BITS-1:0]  shift_q;
  logic [ps2_pkg::FRAME_BITS-1:0]  shift_d;
  logic                            fall_mark;
  logic                            frame_done;
  logic                            wd_run;
  logic                            wd_done;
  logic                            rx_ready_q;

  // ---------------------------------------------------------
  // edge follower
  // ---------------------------------------------------------

  // each marker state lasts exactly one cycle, which gives a single
  // strobe per device clock edge
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ps2_pkg::RX_CLK_HIGH:
      begin
        if (!line.clk_s)
          state_d = ps2_pkg::RX_FALL_MARK;
      end
      ps2_pkg::RX_FALL_MARK: state_d = ps2_pkg::RX_CLK_LOW;
      ps2_pkg::RX_CLK_LOW:
      begin
        if (line.clk_s)
          state_d = ps2_pkg::RX_RISE_MARK;
      end
      ps2_pkg::RX_RISE_MARK: state_d = ps2_pkg::RX_CLK_HIGH;
      default: state_d = ps2_pkg::RX_CLK_HIGH;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state_q <= ps2_pkg::RX_CLK_HIGH;
    else
      state_q <= state_d;
  end

  // the device changes data while its clock is high, so the falling edge
  // is the point where data is stable and gets sampled
  assign fall_mark = (state_q == ps2_pkg::RX_FALL_MARK);

  // ---------------------------------------------------------
  // watchdog
  // ---------------------------------------------------------

  // the timer only runs while the clock is steady and restarts on every edge
  assign wd_run = (state_q == ps2_pkg::RX_CLK_HIGH) || (state_q == ps2_pkg::RX_CLK_LOW);

  ps2_interval_timer #(
    .LIMIT (ps2_pkg::WATCHDOG_CYCLES)
  ) i_watchdog (
    .clk    (clk),
    .reset  (reset),
    .run_i  (wd_run),
    .done_o (wd_done)
  );

  // ---------------------------------------------------------
  // shift register and bit counter
  // ---------------------------------------------------------

  // new bits enter at the top, so after eleven shifts the start bit
  // sits at bit 0 and the data byte occupies bits 8 down to 1
  assign shift_d = {line.data_s, shift_q[ps2_pkg::FRAME_BITS-1:1]};

  // the eleventh marker closes the frame, unless the host has taken the lines
  assign frame_done = fall_mark && !line.tx_active &&
                      (bit_count_q == ps2_pkg::BIT_COUNT_W'(ps2_pkg::FRAME_BITS - 1));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_count_q <= '0;
    // a host write aborts whatever was partially received
    else if (line.tx_active || frame_done)
      bit_count_q <= '0;
    // a long quiet line with the clock high means the device gave up mid frame
    else if (wd_done && (state_q == ps2_pkg::RX_CLK_HIGH) && line.clk_s)
      bit_count_q <= '0;
    else if (fall_mark)
      bit_count_q <= bit_count_q + 1'b1;
  end

  // frame bits and the captured byte are plain data
  always_ff @(posedge clk)
  begin
    if (fall_mark)
      shift_q <= shift_d;
    if (frame_done)
      rx_code_o <= shift_d[8:1];
  end

  // ---------------------------------------------------------
  // ready/read handshake
  // ---------------------------------------------------------

  // a completed frame wins over a read in the same cycle, so an overwrite
  // under back-pressure never loses the ready flag
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      rx_ready_q <= 1'b0;
    else if (frame_done)
      rx_ready_q <= 1'b1;
    else if (rx_read_i)
      rx_ready_q <= 1'b0;
  end

  assign rx_ready_o = rx_ready_q;

endmodule

// ==== ps2_line_frontend.sv ====
// PS/2 line front end: synchronizes both lines and maps drive requests onto open-drain pulls
`timescale 1ns/1ps

module ps2_line_frontend (
  input  logic         clk,
  input  logic         reset,
  input  logic         ps2_clk_i,
  input  logic         ps2_data_i,
  output logic         ps2_clk_pull_o,
  output logic         ps2_data_pull_o,
  ps2_line_if.frontend line
);

  // ---------------------------------------------------------
  // input synchronizers
  // ---------------------------------------------------------

  // bit 0 is the metastable stage, bit 1 is the clean sample
  logic [1:0] clk_sync_q;
  logic [1:0] data_sync_q;

  // both stages come out of reset at the idle level of the bus,
  // so the receiver sees no false falling edge once reset lifts
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      clk_sync_q  <= 2'b11;
      data_sync_q <= 2'b11;
    end
    else
    begin
      clk_sync_q  <= {clk_sync_q[0], ps2_clk_i};
      data_sync_q <= {data_sync_q[0], ps2_data_i};
    end
  end

  // a line change shows up here two clocks later
  assign line.clk_s  = clk_sync_q[1];
  assign line.data_s = data_sync_q[1];

  // ---------------------------------------------------------
  // open-drain drive
  // ---------------------------------------------------------

  // the pad pulls low while a request is up and floats otherwise,
  // the external pull-up brings the line back high;
  // nothing is registered here so a line is released the moment
  // the transmitter drops its request
  assign ps2_clk_pull_o  = line.clk_pull;
  assign ps2_data_pull_o = line.data_pull;

endmodule

// ==== ps2_interval_timer.sv ====
// Interval timer: counts while enabled and flags once a fixed number of clocks has elapsed
`timescale 1ns/1ps

module ps2_interval_timer #(
  parameter int LIMIT = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic run_i,
  output logic done_o
);

  logic [ps2_pkg::TIMER_W-1:0] count_q;

  // done is a pure decode of the count, so it holds as long as run stays high
  assign done_o = (count_q == ps2_pkg::TIMER_W'(LIMIT));

  // the count restarts from zero every time run drops,
  // and it parks at LIMIT instead of wrapping around
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count_q <= '0;
    end
    else if (!run_i)
    begin
      count_q <= '0;
    end
    else if (!done_o)
    begin
      count_q <= count_q + 1'b1;
    end
  end

endmodule

// ==== ps2_line_if.sv ====
// PS/2 line bundle: synchronized line samples and transmit drive-low requests
`timescale 1ns/1ps

interface ps2_line_if;

  // synchronized copies of the two open-drain lines
  logic clk_s;
  logic data_s;

  // drive-low requests from the transmitter, a high value pulls the line
  logic clk_pull;
  logic data_pull;

  // the transmitter owns the lines whenever this is high
  logic tx_active;

  // front end samples the pads and turns the requests into pulls
  modport frontend (
    output clk_s,
    output data_s,
    input  clk_pull,
    input  data_pull
  );

  // receiver only watches the lines
  modport receiver (
    input clk_s,
    input data_s,
    input tx_active
  );

  // transmitter watches the lines and asks for them to be pulled
  modport transmitter (
    input  clk_s,
    input  data_s,
    output clk_pull,
    output data_pull,
    output tx_active
  );

endinterface

// ==== ps2_pkg.sv ====
// PS/2 host port shared definitions: frame size, interval counts, data and state types
package ps2_pkg;

  // ---------------------------------------------------------
  // frame layout
  // ---------------------------------------------------------

  // start bit, eight data bits, odd parity and stop bit
  localparam int FRAME_BITS = 11;

  // wide enough to count up to FRAME_BITS
  localparam int BIT_COUNT_W = 4;

  // ---------------------------------------------------------
  // fixed intervals for a 250 MHz system clock
  // ---------------------------------------------------------

  // 60 us of clock-line inhibit before a host write
  localparam int INHIBIT_CYCLES = 15000;

  // 5 us settle time before a transmit sample edge is trusted
  localparam int DEBOUNCE_CYCLES = 1250;

  // a quiet line for this long drops a partial receive frame
  localparam int WATCHDOG_CYCLES = 15000;

  // the interval timer counter must hold the largest interval above
  localparam int TIMER_W = 14;

  // ---------------------------------------------------------
  // data and state types
  // ---------------------------------------------------------

  // one byte as it travels over the PS/2 lines
  typedef logic [7:0] scan_code_t;

  // receiver follows the device clock with one marker cycle per edge
  typedef enum logic [1:0] {
    RX_CLK_HIGH,
    RX_FALL_MARK,
    RX_CLK_LOW,
    RX_RISE_MARK
  } rx_state_e;

  // transmitter walks a host write from inhibit to acknowledge check
  typedef enum logic [3:0] {
    TX_IDLE,
    TX_LOAD,
    TX_INHIBIT,
    TX_START,
    TX_WAIT_HIGH,
    TX_RISE_MARK,
    TX_CLK_HIGH,
    TX_CLK_LOW,
    TX_WAIT_ACK,
    TX_RECOVER,
    TX_NO_ACK
  } tx_state_e;

endpackage
